// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

  //////////////////////
  // widths
  //////////////////////

  // data and address width of the memory bus
  localparam int unsigned WordW = 32;

  // one byte enable per byte lane
  localparam int unsigned BeW = WordW / 8;

  // byte offset within a word
  localparam int unsigned OffW = $clog2(BeW);

  //////////////////////
  // types
  //////////////////////

  // access size of a load or store
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // bus sequencing states
  // the *_MIS states belong to accesses that are split in two
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } ls_fsm_e;

endpackage

// ==== verilog/lsu_wdata_align.sv ====
`timescale 1ns/1ps

module lsu_wdata_align (
  input  logic [lsu_pkg::WordW-1:0] lsu_addr_i,
  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic [lsu_pkg::WordW-1:0] lsu_wdata_i,
  input  logic                      second_part_i,
  output logic [lsu_pkg::BeW-1:0]   data_be_o,
  output logic [lsu_pkg::WordW-1:0] data_wdata_o
);

  logic [lsu_pkg::OffW-1:0]  offset;
  logic [lsu_pkg::BeW-1:0]   size_mask;
  logic [2*lsu_pkg::BeW-1:0] be_span;

  assign offset = lsu_addr_i[lsu_pkg::OffW-1:0];

  // enables of an access starting at lane 0
  always_comb begin
    unique case (lsu_type_i)
      lsu_pkg::LSU_WORD: size_mask = 4'b1111;
      lsu_pkg::LSU_HALF: size_mask = 4'b0011;
      lsu_pkg::LSU_BYTE: size_mask = 4'b0001;
      default:           size_mask = 4'b0001;
    endcase
  end

  // the shift runs over two words and the upper word holds the bytes that spill
  // into the next word of a split access
  assign be_span = {{lsu_pkg::BeW{1'b0}}, size_mask} << offset;

  always_comb begin
    if (second_part_i) begin
      data_be_o = be_span[2*lsu_pkg::BeW-1:lsu_pkg::BeW];
    end else begin
      data_be_o = be_span[lsu_pkg::BeW-1:0];
    end
  end

  // rotate left by the byte offset
  // the rotated word lines up with the enables of either part
  always_comb begin
    unique case (offset)
      2'd0: begin
        data_wdata_o = lsu_wdata_i;
      end
      2'd1: begin
        data_wdata_o = {lsu_wdata_i[23:0], lsu_wdata_i[31:24]};
      end
      2'd2: begin
        data_wdata_o = {lsu_wdata_i[15:0], lsu_wdata_i[31:16]};
      end
      2'd3: begin
        data_wdata_o = {lsu_wdata_i[7:0], lsu_wdata_i[31:8]};
      end
      default: begin
        data_wdata_o = lsu_wdata_i;
      end
    endcase
  end

endmodule

// ==== verilog/lsu_rdata_align.sv ====
`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      ctrl_update_i,
  input  logic                      rdata_update_i,
  input  logic [lsu_pkg::WordW-1:0] lsu_addr_i,
  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic                      lsu_sign_ext_i,
  input  logic [lsu_pkg::WordW-1:0] data_rdata_i,
  output logic [lsu_pkg::WordW-1:0] lsu_rdata_o
);

  logic [lsu_pkg::OffW-1:0]  offset_q;
  lsu_pkg::lsu_type_e        type_q;
  logic                      sign_ext_q;
  logic [lsu_pkg::WordW-1:8] rdata_q;

  logic [lsu_pkg::WordW-1:0] rdata_word;
  logic [15:0]               rdata_half;
  logic [7:0]                rdata_byte;

  ////////////////////
  // response control
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      type_q     <= lsu_pkg::LSU_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= lsu_addr_i[lsu_pkg::OffW-1:0];
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  // upper three bytes of the first word of a split load
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[lsu_pkg::WordW-1:8];
    end
  end

  ////////////////////
  // realignment
  ////////////////////

  // the low bytes come from the stored first word and the rest from the bus
  always_comb begin
    unique case (offset_q)
      2'd0:    rdata_word = data_rdata_i;
      2'd1:    rdata_word = {data_rdata_i[7:0], rdata_q[31:8]};
      2'd2:    rdata_word = {data_rdata_i[15:0], rdata_q[31:16]};
      2'd3:    rdata_word = {data_rdata_i[23:0], rdata_q[31:24]};
      default: rdata_word = data_rdata_i;
    endcase
  end

  // a half word at offset 3 is the only split half
  always_comb begin
    unique case (offset_q)
      2'd0:    rdata_half = data_rdata_i[15:0];
      2'd1:    rdata_half = data_rdata_i[23:8];
      2'd2:    rdata_half = data_rdata_i[31:16];
      2'd3:    rdata_half = {data_rdata_i[7:0], rdata_q[31:24]};
      default: rdata_half = data_rdata_i[15:0];
    endcase
  end

  assign rdata_byte = data_rdata_i[offset_q*8 +: 8];

  // zero or sign extension
  always_comb begin
    unique case (type_q)
      lsu_pkg::LSU_WORD: lsu_rdata_o = rdata_word;
      lsu_pkg::LSU_HALF: lsu_rdata_o = {{16{sign_ext_q & rdata_half[15]}}, rdata_half};
      lsu_pkg::LSU_BYTE: lsu_rdata_o = {{24{sign_ext_q & rdata_byte[7]}}, rdata_byte};
      default:           lsu_rdata_o = rdata_word;
    endcase
  end

endmodule

// ==== verilog/lsu_bus_ctrl.sv ====
`timescale 1ns/1ps

module lsu_bus_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      lsu_req_i,
  input  logic                      lsu_we_i,
  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic [lsu_pkg::WordW-1:0] lsu_addr_i,
  input  logic                      ds_rdy_i,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic                      data_err_i,
  output logic                      data_req_o,
  output logic [lsu_pkg::WordW-1:0] data_addr_o,
  output logic                      data_we_o,
  output logic                      second_part_o,
  output logic                      ctrl_update_o,
  output logic                      rdata_update_o,
  output logic                      lsu_req_done_o,
  output logic                      lsu_resp_valid_o,
  output logic                      lsu_resp_err_o,
  output logic [lsu_pkg::WordW-1:0] addr_last_o,
  output logic                      busy_o
);

  lsu_pkg::ls_fsm_e ls_fsm_cs, ls_fsm_ns;

  logic                              split_access;
  logic                              handle_misaligned_q, handle_misaligned_d;
  logic                              lsu_err_q, lsu_err_d;
  logic                              outstanding_resp_q;
  logic                              resp_wait;
  logic                              lsu_resp_valid;
  logic                              ls_go;
  logic                              req_done;
  logic                              addr_update;
  logic                              addr_incr;
  logic                              we_q;
  logic [lsu_pkg::WordW-1:0]         addr_q;
  logic [lsu_pkg::WordW-1:0]         addr_first;
  logic [lsu_pkg::WordW-1:0]         addr_second;
  logic [lsu_pkg::WordW-1:0]         addr_last_q;
  logic [lsu_pkg::WordW-1:lsu_pkg::OffW] word_next;

  // misaligned words and a half word crossing into the next word
  assign split_access =
      ((lsu_type_i == lsu_pkg::LSU_WORD) && (lsu_addr_i[lsu_pkg::OffW-1:0] != 2'd0)) ||
      ((lsu_type_i == lsu_pkg::LSU_HALF) && (lsu_addr_i[lsu_pkg::OffW-1:0] == 2'd3));

  ////////////////////
  // addresses
  ////////////////////

  // in IDLE the request is still on the inputs and later it comes from addr_q
  assign addr_first  = (ls_fsm_cs == lsu_pkg::IDLE) ? lsu_addr_i : addr_q;
  assign word_next   = addr_q[lsu_pkg::WordW-1:lsu_pkg::OffW] + 1'b1;
  assign addr_second = {word_next, {lsu_pkg::OffW{1'b0}}};

  // the second address also stays valid after its grant
  assign addr_incr = handle_misaligned_q || (ls_fsm_cs == lsu_pkg::WAIT_RVALID_MIS_GNTS_DONE);

  always_comb begin
    if (handle_misaligned_q) begin
      data_addr_o = addr_second;
    end else begin
      data_addr_o = {addr_first[lsu_pkg::WordW-1:lsu_pkg::OffW], {lsu_pkg::OffW{1'b0}}};
    end
  end

  ////////////////////
  // bus FSM
  ////////////////////

  always_comb begin
    ls_fsm_ns           = ls_fsm_cs;
    data_req_o          = 1'b0;
    handle_misaligned_d = handle_misaligned_q;
    lsu_err_d           = lsu_err_q;
    addr_update         = 1'b0;
    rdata_update_o      = 1'b0;
    ls_go               = 1'b0;
    req_done            = 1'b0;

    unique case (ls_fsm_cs)
      lsu_pkg::IDLE: begin
        if (lsu_req_i && !resp_wait && ds_rdy_i) begin
          data_req_o = 1'b1;
          ls_go      = 1'b1;
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            addr_update         = 1'b1;
            handle_misaligned_d = split_access;
            req_done            = ~split_access;
            ls_fsm_ns = split_access ? lsu_pkg::WAIT_RVALID_MIS : lsu_pkg::IDLE;
          end else begin
            ls_fsm_ns = split_access ? lsu_pkg::WAIT_GNT_MIS : lsu_pkg::WAIT_GNT;
          end
        end
      end

      lsu_pkg::WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          addr_update         = 1'b1;
          handle_misaligned_d = 1'b1;
          ls_fsm_ns           = lsu_pkg::WAIT_RVALID_MIS;
        end
      end

      // second part on the bus while the first part is still in flight
      lsu_pkg::WAIT_RVALID_MIS: begin
        data_req_o = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d           = data_err_i;
          rdata_update_o      = ~we_q;
          addr_update         = data_gnt_i & ~data_err_i;
          req_done            = data_gnt_i;
          handle_misaligned_d = ~data_gnt_i;
          ls_fsm_ns = data_gnt_i ? lsu_pkg::IDLE : lsu_pkg::WAIT_GNT;
        end else if (data_gnt_i) begin
          req_done            = 1'b1;
          handle_misaligned_d = 1'b0;
          ls_fsm_ns           = lsu_pkg::WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      lsu_pkg::WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          // keep the first failing address
          addr_update         = ~lsu_err_q;
          req_done            = 1'b1;
          handle_misaligned_d = 1'b0;
          ls_fsm_ns           = lsu_pkg::IDLE;
        end
      end

      // both parts granted and the first rvalid still missing
      lsu_pkg::WAIT_RVALID_MIS_GNTS_DONE: begin
        if (data_rvalid_i) begin
          lsu_err_d      = data_err_i;
          addr_update    = ~data_err_i;
          rdata_update_o = ~we_q;
          ls_fsm_ns      = lsu_pkg::IDLE;
        end
      end

      default: begin
        ls_fsm_ns = lsu_pkg::IDLE;
      end
    endcase
  end

  // only the last rvalid of an access arrives in IDLE
  assign lsu_resp_valid = data_rvalid_i & outstanding_resp_q & (ls_fsm_cs == lsu_pkg::IDLE);
  assign resp_wait      = outstanding_resp_q & ~lsu_resp_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs           <= lsu_pkg::IDLE;
      handle_misaligned_q <= 1'b0;
      lsu_err_q           <= 1'b0;
      outstanding_resp_q  <= 1'b0;
      we_q                <= 1'b0;
      addr_last_q         <= '0;
    end else begin
      ls_fsm_cs           <= ls_fsm_ns;
      handle_misaligned_q <= handle_misaligned_d;
      lsu_err_q           <= lsu_err_d;
      if (ls_go) begin
        outstanding_resp_q <= 1'b1;
        we_q               <= lsu_we_i;
      end else if (lsu_resp_valid) begin
        outstanding_resp_q <= 1'b0;
      end
      if (addr_update) begin
        addr_last_q <= addr_incr ? addr_second : addr_first;
      end
    end
  end

  // request address for the later states
  always_ff @(posedge clk_i) begin
    if (ls_go) begin
      addr_q <= lsu_addr_i;
    end
  end

  assign data_we_o        = lsu_we_i;
  assign second_part_o    = handle_misaligned_q;
  assign ctrl_update_o    = ls_go;
  assign lsu_req_done_o   = req_done;
  assign lsu_resp_valid_o = lsu_resp_valid;
  assign lsu_resp_err_o   = lsu_resp_valid & (lsu_err_q | data_err_i);
  assign addr_last_o      = addr_last_q;
  assign busy_o           = (ls_fsm_cs != lsu_pkg::IDLE);

endmodule

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // execute stage
  input  logic                      lsu_req_i,
  input  logic                      lsu_we_i,
  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic                      lsu_sign_ext_i,
  input  logic [lsu_pkg::WordW-1:0] lsu_addr_i,
  input  logic [lsu_pkg::WordW-1:0] lsu_wdata_i,
  output logic                      lsu_req_done_o,
  output logic                      lsu_resp_valid_o,
  output logic                      lsu_resp_err_o,
  output logic [lsu_pkg::WordW-1:0] lsu_rdata_o,
  output logic [lsu_pkg::WordW-1:0] addr_last_o,
  output logic                      busy_o,
  input  logic                      ds_rdy_i,
  // data memory bus
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic                      data_err_i,
  output logic [lsu_pkg::WordW-1:0] data_addr_o,
  output logic                      data_we_o,
  output logic [lsu_pkg::BeW-1:0]   data_be_o,
  output logic [lsu_pkg::WordW-1:0] data_wdata_o,
  input  logic [lsu_pkg::WordW-1:0] data_rdata_i
);

  logic second_part;
  logic ctrl_update;
  logic rdata_update;

  lsu_bus_ctrl u_bus_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lsu_req_i        (lsu_req_i),
    .lsu_we_i         (lsu_we_i),
    .lsu_type_i       (lsu_type_i),
    .lsu_addr_i       (lsu_addr_i),
    .ds_rdy_i         (ds_rdy_i),
    .data_gnt_i       (data_gnt_i),
    .data_rvalid_i    (data_rvalid_i),
    .data_err_i       (data_err_i),
    .data_req_o       (data_req_o),
    .data_addr_o      (data_addr_o),
    .data_we_o        (data_we_o),
    .second_part_o    (second_part),
    .ctrl_update_o    (ctrl_update),
    .rdata_update_o   (rdata_update),
    .lsu_req_done_o   (lsu_req_done_o),
    .lsu_resp_valid_o (lsu_resp_valid_o),
    .lsu_resp_err_o   (lsu_resp_err_o),
    .addr_last_o      (addr_last_o),
    .busy_o           (busy_o)
  );

  lsu_wdata_align u_wdata_align (
    .lsu_addr_i    (lsu_addr_i),
    .lsu_type_i    (lsu_type_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .second_part_i (second_part),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .lsu_addr_i     (lsu_addr_i),
    .lsu_type_i     (lsu_type_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .data_rdata_i   (data_rdata_i),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

// ==== verif/lsu_checker.sv ====
`timescale 1ns/1ps

module lsu_checker #(
  parameter int FaultWord = 5,
  parameter int MemBytes  = 128
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      lsu_req_i,
  input  logic                      lsu_we_i,
  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic                      lsu_sign_ext_i,
  input  logic [31:0]               lsu_addr_i,
  input  logic [31:0]               lsu_wdata_i,
  input  logic                      ds_rdy_i,
  input  logic                      lsu_req_done_o,
  input  logic                      lsu_resp_valid_o,
  input  logic                      lsu_resp_err_o,
  input  logic [31:0]               lsu_rdata_o,
  input  logic [31:0]               addr_last_o,
  input  logic                      busy_o,
  input  logic                      data_req_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic [31:0]               data_addr_o,
  input  logic                      data_we_o,
  input  logic [3:0]                data_be_o,
  input  logic [31:0]               data_wdata_o,
  output int                        error_count,
  output int                        resp_count
);

  logic [7:0]  model [MemBytes];
  int          grants, rvalids, pend_parts, inflight;
  logic        pend_valid, pend_we, pend_err, req_active;
  logic [31:0] pend_rdata, pend_last;

  function automatic int unsigned size_bytes(lsu_pkg::lsu_type_e t);
    return (t == lsu_pkg::LSU_WORD) ? 4 : (t == lsu_pkg::LSU_HALF) ? 2 : 1;
  endfunction

  task automatic mismatch(string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    error_count++;
  endtask

  initial begin
    int t;
    for (int i = 0; i < MemBytes; i++) begin
      t = i * 59 + (i >> 3) * 7 + 198;
      model[i] = t[7:0];
    end
    error_count = 0;
    resp_count  = 0;
    grants      = 0;
    rvalids     = 0;
    inflight    = 0;
    pend_valid  = 1'b0;
    req_active  = 1'b0;
  end

  always @(posedge clk_i) begin
    int unsigned a, n, wa, b;
    logic [3:0]  be;
    logic        split, f1, f2;
    logic [31:0] val;
    if (rst_ni) begin
      a = lsu_addr_i;
      n = size_bytes(lsu_type_i);
      split = ((a % 4) + n) > 4;
      if (data_req_o && pend_valid && !lsu_resp_valid_o)
        mismatch("bus request before the previous response");
      if (data_req_o && !req_active && !ds_rdy_i)
        mismatch("new bus request while ds_rdy_i is low");
      // busy from the second cycle of a request until one part is left in flight
      if (busy_o != (req_active || inflight > 1))
        mismatch($sformatf("busy %b with %0d parts in flight", busy_o, inflight));
      ////////////////////
      // bus write side
      ////////////////////
      if (data_req_o && data_gnt_i) begin
        wa = data_addr_o;
        if (wa != (a & ~32'd3) + 4 * grants)
          mismatch($sformatf("part %0d address %h for request %h", grants, wa, a));
        for (int k = 0; k < 4; k++) begin
          b = wa + k;
          be[k] = (b >= a) && (b < a + n);
          if (be[k] && lsu_we_i && data_wdata_o[8*k +: 8] != lsu_wdata_i[8*(b-a) +: 8])
            mismatch($sformatf("store byte %0d of word %h", k, wa));
        end
        if (data_be_o != be || data_we_o != lsu_we_i)
          mismatch($sformatf("byte enables %b, expected %b", data_be_o, be));
        grants++;
        inflight++;
      end
      if (data_req_o)
        req_active = 1'b1;
      if (data_rvalid_i) begin
        rvalids++;
        inflight--;
      end
      ////////////////////
      // response side
      ////////////////////
      if (lsu_resp_valid_o) begin
        if (!pend_valid) begin
          $display("response seen without an accepted request at %0t", $time);
          error_count++;
        end else begin
          if (!data_rvalid_i || rvalids != pend_parts)
            mismatch($sformatf("response after %0d of %0d rvalids", rvalids, pend_parts));
          if (lsu_resp_err_o != pend_err)
            mismatch($sformatf("error flag %b, expected %b", lsu_resp_err_o, pend_err));
          if (addr_last_o != pend_last)
            mismatch($sformatf("addr_last %h, expected %h", addr_last_o, pend_last));
          if (!pend_we && !pend_err && lsu_rdata_o != pend_rdata)
            mismatch($sformatf("load data %h, expected %h", lsu_rdata_o, pend_rdata));
        end
        resp_count++;
        pend_valid = 1'b0;
        rvalids    = 0;
      end
      if (lsu_req_i && lsu_req_done_o) begin
        pend_parts = split ? 2 : 1;
        if (grants != pend_parts)
          mismatch($sformatf("%0d grants for request %h, expected %0d", grants, a, pend_parts));
        if (!(data_req_o && data_gnt_i))
          mismatch($sformatf("request %h done outside a grant cycle", a));
        grants = 0;
        req_active = 1'b0;
        f1 = (a / 4) == FaultWord;
        f2 = split && ((a / 4) + 1 == FaultWord);
        pend_err  = f1 || f2;
        pend_last = (split && !f1) ? (a & ~32'd3) + 4 : a;
        pend_we   = lsu_we_i;
        val = '0;
        for (int i = 0; i < n; i++) begin
          if (lsu_we_i && ((a + i) / 4 != FaultWord))
            model[a+i] = lsu_wdata_i[8*i +: 8];
          val[8*i +: 8] = model[a+i];
        end
        if (lsu_sign_ext_i && n == 1 && val[7])
          val[31:8] = '1;
        if (lsu_sign_ext_i && n == 2 && val[15])
          val[31:16] = '1;
        pend_rdata = val;
        pend_valid = 1'b1;
      end
    end
  end

endmodule

// ==== verif/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;

  localparam int NumTxn    = 300;
  localparam int MemBytes  = 128;
  localparam int FaultWord = 5;
  localparam int MaxCycles = NumTxn * 40;

  integer seed = 32'hba0a225a;
  logic clk_i, rst_ni, lsu_req_i, lsu_we_i, lsu_sign_ext_i, ds_rdy_i;
  lsu_pkg::lsu_type_e lsu_type_i;
  logic [31:0] lsu_addr_i, lsu_wdata_i, lsu_rdata_o, addr_last_o;
  logic lsu_req_done_o, lsu_resp_valid_o, lsu_resp_err_o, busy_o;
  logic data_req_o, data_gnt_i, data_rvalid_i, data_err_i, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;
  logic [3:0]  data_be_o;
  int error_count, resp_count, cycles, gnt_wait, resp_cyc;
  logic [7:0]  mem [MemBytes];
  logic [31:0] rnd;
  logic [31:0] req_rnd;
  int q_due[$];
  logic [31:0] q_rdata[$];
  logic q_err[$];

  lsu_top uut (.*);

  lsu_checker #(.FaultWord(FaultWord), .MemBytes(MemBytes)) u_checker (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // memory responder with random grant and rvalid latency
  always @(posedge clk_i) begin
    int unsigned wa;
    int due;
    if (rst_ni) begin
      resp_cyc++;
      if (data_rvalid_i) begin
        void'(q_due.pop_front());
        void'(q_rdata.pop_front());
        void'(q_err.pop_front());
      end
      rnd = $random(seed);
      if (data_req_o && data_gnt_i) begin
        wa = data_addr_o[6:0];
        q_rdata.push_back({mem[wa+3], mem[wa+2], mem[wa+1], mem[wa]});
        q_err.push_back(wa / 4 == FaultWord);
        if (data_we_o && wa / 4 != FaultWord)
          for (int k = 0; k < 4; k++)
            if (data_be_o[k]) mem[wa+k] = data_wdata_o[8*k +: 8];
        due = resp_cyc + 1 + int'(rnd[3:2]) % 3;
        if (q_due.size() > 0 && due <= q_due[$])
          due = q_due[$] + 1;
        q_due.push_back(due);
        gnt_wait = int'(rnd[1:0]);
      end else if (data_req_o && gnt_wait > 0) begin
        gnt_wait--;
      end
      #1;
      data_gnt_i = (gnt_wait == 0);
      ds_rdy_i   = (rnd[5:4] != 2'd0);
      data_rvalid_i = (q_due.size() > 0) && (q_due[0] == resp_cyc + 1);
      data_rdata_i  = data_rvalid_i ? q_rdata[0] : '0;
      data_err_i    = data_rvalid_i ? q_err[0] : 1'b0;
    end
  end

  // cycle limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("timeout: run did not finish, %0d of %0d responses and %0d errors after %0d cycles",
               resp_count, NumTxn, error_count, cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    int t;
    for (int i = 0; i < MemBytes; i++) begin
      t = i * 59 + (i >> 3) * 7 + 198;
      mem[i] = t[7:0];
    end
    {rst_ni, lsu_req_i, lsu_we_i, lsu_sign_ext_i, ds_rdy_i} = 5'b00001;
    {data_gnt_i, data_rvalid_i, data_err_i} = 3'b000;
    lsu_type_i = lsu_pkg::LSU_WORD;
    {lsu_addr_i, lsu_wdata_i, data_rdata_i} = '0;
    {cycles, gnt_wait, resp_cyc} = '0;
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    for (int n = 0; n < NumTxn; n++) begin
      req_rnd = $random(seed);
      lsu_req_i      = 1'b1;
      lsu_we_i       = req_rnd[0];
      lsu_sign_ext_i = req_rnd[4];
      lsu_addr_i     = {26'd0, req_rnd[10:5]};
      case (int'(req_rnd[3:1]) % 3)
        0:       lsu_type_i = lsu_pkg::LSU_WORD;
        1:       lsu_type_i = lsu_pkg::LSU_HALF;
        default: lsu_type_i = lsu_pkg::LSU_BYTE;
      endcase
      lsu_wdata_i = $random(seed);
      do @(posedge clk_i); while (!lsu_req_done_o);
      #1;
    end
    lsu_req_i = 1'b0;
    while (resp_count < NumTxn) @(posedge clk_i);
    @(posedge clk_i);
    $display("checker: %0d errors in %0d responses", error_count, resp_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== lsu_top.f ====
verilog/lsu_pkg.sv
verilog/lsu_wdata_align.sv
verilog/lsu_rdata_align.sv
verilog/lsu_bus_ctrl.sv
verilog/lsu_top.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0 -Wno-fatal
TOP      = lsu_tb
FILELIST = lsu_top.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
